/* branch_back.sv */
// backward-branch detection on the head pair
// decodes both head words through the branch view, picks the oldest
// valid backward branch and computes its target
`timescale 1ns/1ps
`default_nettype none

module branch_back import fetch_pkg::*; (
	input  wire logic  head_v0,
	input  wire logic  head_v1,
	input  wire insn_t head_insn0,	// oldest word
	input  wire insn_t head_insn1,
	input  wire addr_t head_pc0,
	input  wire addr_t head_pc1,
	output logic       back_slot,	// 0 when slot 0 holds the branch
	output addr_t      back_target,
	output logic       back_found
);

	logic  bb0, bb1;	// per slot backward-branch hit
	addr_t tgt0, tgt1;

	// ========================================================================
	// decode
	// ========================================================================
	always_comb begin
		bb0  = head_v0 & is_back_branch(head_insn0);
		bb1  = head_v1 & is_back_branch(head_insn1);
		tgt0 = branch_target(head_pc0, head_insn0);
		tgt1 = branch_target(head_pc1, head_insn1);
	end

	// ========================================================================
	// oldest branch wins
	// ========================================================================
	always_comb begin
		back_found = bb0 | bb1;
		if (bb0) begin
			back_slot   = 1'b0;
			back_target = tgt0;
		end else begin
			back_slot   = 1'b1;	// don't care unless bb1
			back_target = tgt1;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
fetch_pkg.sv
fetch_pc.sv
fetch_buffer_pair.sv
fetch_steer.sv
branch_back.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

/* fetch_buffer_pair.sv */
// one pair of fetch-buffer slots
// each slot holds an instruction word, its pc and a valid bit
// loaded two at a time from the cache, retired one slot at a time
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_pair import fetch_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  load,	// fill both slots from the cache
	input  wire addr_t load_pc,	// pc of the first word
	input  wire insn_t load_insn0,
	input  wire insn_t load_insn1,
	input  wire logic  clear_slot0,	// slot 0 enqueued
	input  wire logic  clear_slot1,	// slot 1 enqueued
	input  wire logic  flush,	// drop both slots
	output logic       valid0,
	output logic       valid1,
	output insn_t      insn0,
	output insn_t      insn1,
	output addr_t      pc0,
	output addr_t      pc1
);

	// ========================================================================
	// valid bits
	// ========================================================================
	// flush beats everything, a load only arrives into an empty pair
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid0 <= 1'b0;
			valid1 <= 1'b0;
		end else if (flush) begin
			valid0 <= 1'b0;
			valid1 <= 1'b0;
		end else if (load) begin
			valid0 <= 1'b1;
			valid1 <= 1'b1;
		end else begin
			if (clear_slot0)
				valid0 <= 1'b0;
			if (clear_slot1)
				valid1 <= 1'b0;
		end
	end

	// ========================================================================
	// payload
	// ========================================================================
	// words and pcs are only meaningful while the matching valid is set
	always_ff @(posedge clk) begin
		if (load) begin
			insn0 <= load_insn0;
			insn1 <= load_insn1;
			pc0   <= load_pc;
			pc1   <= load_pc + addr_t'(INSN_BYTES);	// second word follows the first
		end
	end

endmodule

`default_nettype wire

/* fetch_checker.sv */
// bound assertions for the fetch stage
// enqueue ordering, quiet miss cycle and the issue-queue credit limit
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
	parameter int QUEUE_DEPTH = 8
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic branchmiss,
	input wire logic credit_ret,
	input wire logic enq0_v,
	input wire logic enq1_v
);

	int held;	// credits the stage may still spend

	// ========================================================================
	// credit shadow
	// ========================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			held <= QUEUE_DEPTH;
		else
			held <= held - int'(enq0_v) - int'(enq1_v) + int'(credit_ret);
	end

	// ========================================================================
	// properties
	// ========================================================================
	a_enq_order: assert property (@(posedge clk) disable iff (rst) enq1_v |-> enq0_v)
		else $error("enq1_v rose without enq0_v");
	a_credit: assert property (@(posedge clk) disable iff (rst)
		(int'(enq0_v) + int'(enq1_v)) <= held)
		else $error("more enqueues than credits held");
	a_miss_quiet: assert property (@(posedge clk) disable iff (rst)
		branchmiss |-> !(enq0_v || enq1_v))
		else $error("enqueue during a branch miss");

endmodule

bind fetch_top fetch_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch_checker (
	.clk(clk), .rst(rst), .branchmiss(branchmiss), .credit_ret(credit_ret),
	.enq0_v(enq0_v), .enq1_v(enq1_v)
);

`default_nettype wire

/* fetch_pc.sv */
// fetch program counter
// next-pc selection between branch miss, backward branch and sequential
// fetch, registered at every edge
`timescale 1ns/1ps
`default_nettype none

module fetch_pc import fetch_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  branchmiss,	// redirect from the core
	input  wire addr_t misspc,
	input  wire logic  back_taken,	// backward branch enqueued this cycle
	input  wire addr_t back_target,
	input  wire logic  fetch_accept,	// cache words taken into a pair
	output addr_t      pc
);

	// ========================================================================
	// constants
	// ========================================================================
	localparam addr_t RESET_VEC    = '0;
	localparam addr_t FETCH_STRIDE = addr_t'(2 * INSN_BYTES);	// two words per fetch

	addr_t pc_next;

	// ========================================================================
	// next pc
	// ========================================================================
	// priority: miss, then backward branch, then sequential, else hold
	always_comb begin
		pc_next = pc;	// hold while no pair is free or no hit
		if (branchmiss) begin
			pc_next = misspc;
		end else if (back_taken) begin
			pc_next = back_target;	// same edge as the buffer flush
		end else if (fetch_accept) begin
			pc_next = pc + FETCH_STRIDE;
		end
	end

	// ========================================================================
	// pc register
	// ========================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= RESET_VEC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

/* fetch_pkg.sv */
// fetch stage package
// address and instruction widths, opcodes, the instruction word union
// and the backward-branch decode helpers
`default_nettype none

package fetch_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int ADDR_W     = 32;	// byte address
	localparam int INSN_W     = 32;	// one word per fetch-buffer slot
	localparam int INSN_BYTES = 4;	// stride between sequential instructions
	localparam int DISP_W     = 20;	// branch displacement, in instructions

	typedef logic [ADDR_W-1:0] addr_t;

	// opcodes live in the low 7 bits of every word
	localparam logic [6:0] OP_NOP     = 7'h13;
	localparam logic [6:0] OP_BR_BACK = 7'h63;	// pc relative branch

	// ========================================================================
	// instruction word
	// ========================================================================
	// fetch only cares about the opcode and, for branches, the displacement
	typedef union packed {
		struct packed {
			logic [INSN_W-8:0] body;	// opaque to fetch
			logic [6:0]        opcode;
		} gen;
		struct packed {
			logic signed [DISP_W-1:0]   disp;	// signed, instruction units
			logic [INSN_W-DISP_W-8:0]   rsvd;	// unused by fetch
			logic [6:0]                 opcode;
		} br;
	} insn_t;

	// ========================================================================
	// decode helpers
	// ========================================================================
	// backward means negative displacement, sign bit of the branch view
	function automatic logic is_back_branch(insn_t insn);
		return (insn.gen.opcode == OP_BR_BACK) && insn.br.disp[DISP_W-1];
	endfunction

	// target = pc + disp * INSN_BYTES, disp sign extended to address width
	function automatic addr_t branch_target(addr_t pc, insn_t insn);
		addr_t disp_ext;
		disp_ext = {{(ADDR_W-DISP_W){insn.br.disp[DISP_W-1]}}, insn.br.disp};
		return pc + disp_ext * addr_t'(INSN_BYTES);
	endfunction

endpackage

`default_nettype wire

/* fetch_steer.sv */
// fetch-buffer steering
// ping-pong pointer over the a/b and c/d pairs, issue-queue credit counter,
// enqueue decisions for the head pair and refill selection
`timescale 1ns/1ps
`default_nettype none

module fetch_steer import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 8	// issue-queue credits, 2 to 15
) (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  branchmiss,
	input  wire logic  credit_ret,	// one credit back from the queue
	input  wire logic  hit,	// cache has words for pc
	input  wire logic  back_found,	// backward branch in the head pair
	input  wire logic  back_slot,	// which head slot holds it
	// a/b pair state
	input  wire logic  ab_v0,
	input  wire logic  ab_v1,
	input  wire insn_t ab_insn0,
	input  wire insn_t ab_insn1,
	input  wire addr_t ab_pc0,
	input  wire addr_t ab_pc1,
	// c/d pair state
	input  wire logic  cd_v0,
	input  wire logic  cd_v1,
	input  wire insn_t cd_insn0,
	input  wire insn_t cd_insn1,
	input  wire addr_t cd_pc0,
	input  wire addr_t cd_pc1,
	// pair control
	output logic       load_ab,
	output logic       load_cd,
	output logic       clear_ab0,
	output logic       clear_ab1,
	output logic       clear_cd0,
	output logic       clear_cd1,
	output logic       flush,	// both pairs
	output logic       fetch_accept,
	output logic       back_taken,
	// head pair, oldest valid word first
	output logic       head_v0,
	output logic       head_v1,
	output insn_t      head_insn0,
	output insn_t      head_insn1,
	output addr_t      head_pc0,
	output addr_t      head_pc1,
	output logic       enq0_v,
	output logic       enq1_v
);

	localparam int CW = $clog2(QUEUE_DEPTH + 1);	// credit counter width

	logic          ptr;	// fetchbuf pointer, 0 selects a/b as head
	logic [CW-1:0] credits;	// free issue-queue entries
	logic          hv0, hv1;	// head pair physical valids
	logic          ov0, ov1;	// other pair physical valids
	insn_t         hi0, hi1;
	addr_t         hp0, hp1;
	logic          clr0, clr1;	// head slot retire, physical
	logic          head_done;	// head pair empty after this edge
	logic          other_busy;	// other pair holds or receives words
	logic          free_ab, free_cd;
	logic [1:0]    n_spend;

	// ========================================================================
	// head pair select and compaction
	// ========================================================================
	always_comb begin
		hv0 = ptr ? cd_v0    : ab_v0;
		hv1 = ptr ? cd_v1    : ab_v1;
		hi0 = ptr ? cd_insn0 : ab_insn0;
		hi1 = ptr ? cd_insn1 : ab_insn1;
		hp0 = ptr ? cd_pc0   : ab_pc0;
		hp1 = ptr ? cd_pc1   : ab_pc1;
		ov0 = ptr ? ab_v0    : cd_v0;
		ov1 = ptr ? ab_v1    : cd_v1;
	end

	// slot 1 alone moves down so head slot 0 is always the oldest word
	assign head_v0    = hv0 | hv1;
	assign head_v1    = hv0 & hv1;
	assign head_insn0 = hv0 ? hi0 : hi1;
	assign head_pc0   = hv0 ? hp0 : hp1;
	assign head_insn1 = hi1;
	assign head_pc1   = hp1;

	// ========================================================================
	// enqueue
	// ========================================================================
	// never more enqueues than credits, nothing during a miss
	assign enq0_v = ~branchmiss & head_v0 & (credits != '0);
	assign enq1_v = ~branchmiss & head_v1 & (credits > CW'(1))
		& ~(back_found & ~back_slot);	// younger word after a branch is dropped
	assign back_taken = back_found & (back_slot ? enq1_v : enq0_v);

	assign clr0 = enq0_v & hv0;
	assign clr1 = (enq0_v & ~hv0) | enq1_v;	// compacted slot 0 may be physical 1

	assign clear_ab0 = ~ptr & clr0;
	assign clear_ab1 = ~ptr & clr1;
	assign clear_cd0 = ptr & clr0;
	assign clear_cd1 = ptr & clr1;
	assign flush     = branchmiss | back_taken;	// redirect empties everything

	// ========================================================================
	// refill
	// ========================================================================
	assign free_ab      = ~ab_v0 & ~ab_v1;
	assign free_cd      = ~cd_v0 & ~cd_v1;
	assign fetch_accept = hit & (free_ab | free_cd) & ~flush;	// wrong-path hit dropped
	assign load_ab      = fetch_accept & free_ab;	// a/b wins a tie
	assign load_cd      = fetch_accept & ~free_ab;

	// ========================================================================
	// pointer and credits
	// ========================================================================
	assign head_done  = (~hv0 | clr0) & (~hv1 | clr1);
	assign other_busy = ov0 | ov1 | (ptr ? load_ab : load_cd);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= 1'b0;
		end else if (flush) begin
			ptr <= 1'b0;
		end else if (head_done) begin
			ptr <= other_busy ? ~ptr : 1'b0;	// both empty parks on a/b
		end
	end

	assign n_spend = {1'b0, enq0_v} + {1'b0, enq1_v};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits <= CW'(QUEUE_DEPTH);
		end else begin
			credits <= credits - CW'(n_spend) + CW'(credit_ret);
		end
	end

endmodule

`default_nettype wire

/* fetch_top.sv */
// instruction fetch stage top level
// cache port, credit-based issue-queue port, pc, two fetch-buffer pairs,
// steering and backward-branch detection
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 8	// issue-queue entries
) (
	input  wire logic  clk,
	input  wire logic  rst,
	// cache
	input  wire logic  hit,
	input  wire insn_t inst0,	// word at pc_i
	input  wire insn_t inst1,	// word at pc_i + INSN_BYTES
	input  wire addr_t pc_i,
	// core redirect
	input  wire logic  branchmiss,
	input  wire addr_t misspc,
	// issue queue
	input  wire logic  credit_ret,
	output addr_t      pc,
	output logic       enq0_v,
	output insn_t      enq0_insn,
	output addr_t      enq0_pc,
	output logic       enq1_v,
	output insn_t      enq1_insn,
	output addr_t      enq1_pc
);

	// pair state
	logic  ab_v0, ab_v1, cd_v0, cd_v1;
	insn_t ab_insn0, ab_insn1, cd_insn0, cd_insn1;
	addr_t ab_pc0, ab_pc1, cd_pc0, cd_pc1;
	// pair control
	logic  load_ab, load_cd, flush;
	logic  clear_ab0, clear_ab1, clear_cd0, clear_cd1;
	// head pair and redirect
	logic  head_v0, head_v1;
	logic  fetch_accept;
	logic  back_found, back_slot, back_taken;
	addr_t back_target;

	// ========================================================================
	// pc
	// ========================================================================
	fetch_pc u_fetch_pc (
		.clk(clk), .rst(rst),
		.branchmiss(branchmiss), .misspc(misspc),
		.back_taken(back_taken), .back_target(back_target),
		.fetch_accept(fetch_accept), .pc(pc)
	);

	// ========================================================================
	// fetch buffers
	// ========================================================================
	fetch_buffer_pair u_pair_ab (
		.clk(clk), .rst(rst), .load(load_ab), .load_pc(pc_i),
		.load_insn0(inst0), .load_insn1(inst1),
		.clear_slot0(clear_ab0), .clear_slot1(clear_ab1), .flush(flush),
		.valid0(ab_v0), .valid1(ab_v1), .insn0(ab_insn0), .insn1(ab_insn1),
		.pc0(ab_pc0), .pc1(ab_pc1)
	);

	fetch_buffer_pair u_pair_cd (
		.clk(clk), .rst(rst), .load(load_cd), .load_pc(pc_i),
		.load_insn0(inst0), .load_insn1(inst1),
		.clear_slot0(clear_cd0), .clear_slot1(clear_cd1), .flush(flush),
		.valid0(cd_v0), .valid1(cd_v1), .insn0(cd_insn0), .insn1(cd_insn1),
		.pc0(cd_pc0), .pc1(cd_pc1)
	);

	// ========================================================================
	// steering, head words go straight out as the enqueue payload
	// ========================================================================
	fetch_steer #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch_steer (
		.clk(clk), .rst(rst), .branchmiss(branchmiss), .credit_ret(credit_ret),
		.hit(hit), .back_found(back_found), .back_slot(back_slot),
		.ab_v0(ab_v0), .ab_v1(ab_v1), .ab_insn0(ab_insn0), .ab_insn1(ab_insn1),
		.ab_pc0(ab_pc0), .ab_pc1(ab_pc1),
		.cd_v0(cd_v0), .cd_v1(cd_v1), .cd_insn0(cd_insn0), .cd_insn1(cd_insn1),
		.cd_pc0(cd_pc0), .cd_pc1(cd_pc1),
		.load_ab(load_ab), .load_cd(load_cd),
		.clear_ab0(clear_ab0), .clear_ab1(clear_ab1),
		.clear_cd0(clear_cd0), .clear_cd1(clear_cd1),
		.flush(flush), .fetch_accept(fetch_accept), .back_taken(back_taken),
		.head_v0(head_v0), .head_v1(head_v1),
		.head_insn0(enq0_insn), .head_insn1(enq1_insn),
		.head_pc0(enq0_pc), .head_pc1(enq1_pc),
		.enq0_v(enq0_v), .enq1_v(enq1_v)
	);

	branch_back u_branch_back (
		.head_v0(head_v0), .head_v1(head_v1),
		.head_insn0(enq0_insn), .head_insn1(enq1_insn),
		.head_pc0(enq0_pc), .head_pc1(enq1_pc),
		.back_slot(back_slot), .back_target(back_target), .back_found(back_found)
	);

endmodule

`default_nettype wire

/* tb_fetch.sv */
// testbench for the fetch stage
// clock and reset, cache model, credit-returning issue-queue model,
// reference program walk and enqueue compare, five directed and random tests
`timescale 1ns/1ps
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

	localparam int QD       = 8;	// issue-queue depth given to the DUT
	localparam int T1       = 400;	// per-test cycle budgets
	localparam int T2       = 400;
	localparam int T3       = 800;
	localparam int T4       = 400;
	localparam int T5       = 2000;
	localparam int T5_DRAIN = 200;
	localparam int WATCHDOG_NS = (16 + T1 + T2 + T3 + T4 + T5 + T5_DRAIN + 500) * 4;

	logic  clk = 1'b0;
	logic  rst, hit, branchmiss, credit_ret;
	insn_t inst0, inst1, enq0_insn, enq1_insn;
	addr_t pc_i, misspc, pc, enq0_pc, enq1_pc;
	logic  enq0_v, enq1_v;

	logic [31:0] rng = 32'd31114;	// xorshift state
	int    errors, enq_count, cycle, held, hit_thr;
	int    test_enq0, test_err0;
	int    br_seen [2];	// backward branches seen per enqueue port
	int    pend [$];	// due cycles of credits still owed by the queue
	logic  withhold, rand_miss, miss_req;
	addr_t miss_addr, exp_pc;
	logic  redir_chk;	// pc redirect due in the next cycle
	addr_t redir_pc;

	fetch_top #(.QUEUE_DEPTH(QD)) u_fetch_top (
		.clk(clk), .rst(rst), .hit(hit), .inst0(inst0), .inst1(inst1), .pc_i(pc_i),
		.branchmiss(branchmiss), .misspc(misspc), .credit_ret(credit_ret),
		.pc(pc), .enq0_v(enq0_v), .enq0_insn(enq0_insn), .enq0_pc(enq0_pc),
		.enq1_v(enq1_v), .enq1_insn(enq1_insn), .enq1_pc(enq1_pc)
	);

	always #2 clk = ~clk;	// 4 ns period

	// ========================================================================
	// program model and reference
	// ========================================================================
	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// backward branch at every 0x..3c from 0x1000 up with an odd or even loop body
	function automatic insn_t prog_word(input addr_t a);
		insn_t w;
		if (a >= 32'h1000 && a[7:0] == 8'h3c) begin
			w.br.opcode = OP_BR_BACK;
			w.br.rsvd   = '0;
			w.br.disp   = a[12] ? -20'sd4 : -20'sd5;
		end else begin
			w.gen.opcode = OP_NOP;
			w.gen.body   = a[31:7] ^ a[24:0];	// every address bit shows up
		end
		return w;
	endfunction

	// expected word at a and the pc of the next instruction in program order
	function automatic addr_t ref_step(input addr_t a, output insn_t word);
		logic [31:0] raw;
		word = prog_word(a);
		raw  = word;
		if (raw[6:0] == OP_BR_BACK && raw[31])
			return a + addr_t'({{12{raw[31]}}, raw[31:12]} * INSN_BYTES);	// taken
		return a + addr_t'(INSN_BYTES);
	endfunction

	task automatic check_enq(input int port, input addr_t got_pc, input insn_t got_insn);
		insn_t exp_insn;
		addr_t nxt;
		nxt = ref_step(exp_pc, exp_insn);
		if (got_pc !== exp_pc) begin
			errors++;
			$display("Fail %0t: enq%0d pc %h, expected %h", $time, port, got_pc, exp_pc);
			nxt = ref_step(got_pc, exp_insn);	// resync to limit follow-on errors
		end else if (got_insn !== exp_insn) begin
			errors++;
			$display("Fail %0t: enq%0d word %h at pc %h, expected %h",
				$time, port, got_insn, got_pc, exp_insn);
		end
		if (got_insn[6:0] == OP_BR_BACK && got_insn[31]) begin
			br_seen[port]++;
			redir_chk = 1'b1;	// fetch pc jumps to the target at this edge
			redir_pc  = nxt;
		end
		exp_pc = nxt;
	endtask

	// ========================================================================
	// stimulus, cache and queue model
	// ========================================================================
	always @(posedge clk) begin : drive
		logic [31:0] r;
		#0.5;
		r          = xorshift32();
		hit        = (int'(r[7:0]) < hit_thr);
		pc_i       = pc;	// cache answers for the current pc
		inst0      = prog_word(pc);
		inst1      = prog_word(pc + addr_t'(INSN_BYTES));
		credit_ret = 1'b0;
		if (!withhold && pend.size() > 0 && pend[0] <= cycle) begin
			credit_ret = 1'b1;	// one credit per cycle at most
			void'(pend.pop_front());
		end
		branchmiss = 1'b0;
		if (miss_req) begin
			branchmiss = 1'b1;
			misspc     = miss_addr;
			miss_req   = 1'b0;
		end else if (rand_miss && r[31:26] == 6'd0) begin
			branchmiss = 1'b1;
			misspc     = r & 32'h0000_3ffc;	// anywhere in the straight or loop regions
		end
	end

	// outputs settle by mid-cycle and the enqueue itself happens at the next rise
	always @(negedge clk) begin : compare
		int n;
		n = 0;
		if (rst) begin
			held      = QD;
			exp_pc    = '0;	// reset vector
			redir_chk = 1'b0;
		end else begin
			if (redir_chk && pc !== redir_pc) begin
				errors++;
				$display("Fail %0t: pc %h one cycle after a redirect, expected %h",
					$time, pc, redir_pc);
			end
			redir_chk = 1'b0;
			if (enq1_v && !enq0_v) begin
				errors++;
				$display("Fail %0t: enq1_v high without enq0_v", $time);
			end
			if (branchmiss && (enq0_v || enq1_v)) begin
				errors++;
				$display("Fail %0t: enqueue in a branch miss cycle", $time);
			end
			if (enq0_v) begin
				check_enq(0, enq0_pc, enq0_insn);
				n++;
			end
			if (enq1_v) begin
				check_enq(1, enq1_pc, enq1_insn);
				n++;
			end
			if (n > held) begin
				errors++;
				$display("Fail %0t: %0d enqueues with %0d credits held", $time, n, held);
			end
			repeat (n) pend.push_back(cycle + 1 + int'(xorshift32() & 32'd3));
			held = held - n + int'(credit_ret);
			enq_count += n;
			if (branchmiss) begin
				exp_pc    = misspc;	// stream restarts at the miss target
				redir_chk = 1'b1;
				redir_pc  = misspc;
			end
			cycle++;
		end
	end

	// ========================================================================
	// test helpers
	// ========================================================================
	task automatic wait_enqueues(input int n, input int max_cycles);
		int target;
		int k;
		target = enq_count + n;
		k = 0;
		while (enq_count < target && k < max_cycles) begin
			@(posedge clk);
			k++;
		end
		if (enq_count < target) begin
			errors++;
			$display("timeout: only %0d of %0d enqueues arrived within %0d cycles",
				n - (target - enq_count), n, max_cycles);
		end
	endtask

	task automatic request_miss(input addr_t target);
		miss_addr = target;
		miss_req  = 1'b1;
		while (miss_req)
			@(posedge clk);
	endtask

	task automatic begin_test();
		test_enq0 = enq_count;
		test_err0 = errors;
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d enqueues, %0d errors",
			num, name, enq_count - test_enq0, errors - test_err0);
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================
	initial begin
		rst        = 1'b1;
		hit        = 1'b0;
		inst0      = '0;
		inst1      = '0;
		pc_i       = '0;
		branchmiss = 1'b0;
		misspc     = '0;
		credit_ret = 1'b0;
		errors     = 0;
		enq_count  = 0;
		cycle      = 0;
		held       = QD;
		hit_thr    = 256;	// every cycle hits
		withhold   = 1'b0;
		rand_miss  = 1'b0;
		miss_req   = 1'b0;
		miss_addr  = '0;
		exp_pc     = '0;
		redir_chk  = 1'b0;
		redir_pc   = '0;
		br_seen[0] = 0;
		br_seen[1] = 0;
		repeat (16) @(posedge clk);
		#0.5;
		rst = 1'b0;

		begin_test();
		wait_enqueues(60, T1);	// stays below the branch region
		end_test(1, "straight-line");

		begin_test();
		withhold = 1'b1;
		repeat (40) @(posedge clk);
		if (held != 0) begin
			errors++;
			$display("Fail %0t: %0d credits left while withheld, expected 0", $time, held);
		end
		withhold = 1'b0;
		wait_enqueues(24, T2 - 40);
		end_test(2, "credit starvation");

		begin_test();
		request_miss(32'h1030);	// branch in slot 1 on the first pass and in slot 0 after
		wait_enqueues(40, T3 / 2);
		request_miss(32'h203c);	// branch in slot 0 on the first pass and in slot 1 after
		wait_enqueues(40, T3 / 2);
		if (br_seen[0] == 0 || br_seen[1] == 0) begin
			errors++;
			$display("Fail %0t: backward branch not enqueued from both slots", $time);
		end
		end_test(3, "backward branch");

		begin_test();
		wait_enqueues(6, T4 / 4);
		request_miss(32'h0800);
		wait_enqueues(12, T4 / 4);
		request_miss(32'h0a04);	// odd pair alignment
		wait_enqueues(12, T4 / 4);
		request_miss(32'h3034);
		wait_enqueues(20, T4 / 4);
		end_test(4, "branch miss");

		begin_test();
		hit_thr   = 192;	// about three hits in four
		rand_miss = 1'b1;
		repeat (T5) @(posedge clk);
		rand_miss = 1'b0;
		hit_thr   = 256;
		wait_enqueues(8, T5_DRAIN);
		if (enq_count - test_enq0 < T5 / 8) begin
			errors++;
			$display("Fail %0t: random traffic stalled at %0d enqueues",
				$time, enq_count - test_enq0);
		end
		end_test(5, "random traffic");

		$display("5 tests, %0d enqueues, %0d errors", enq_count, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// hard stop if a test never returns
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
